// ==== Makefile ====
# Verilator build and run of the descriptor front end testbench

TOP      ?= tb_desc64_frontend
FILELIST ?= project.f
FLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR  ?= obj_dir

.PHONY: sim clean

# the run passes only when the pass message shows up in its output
sim:
	verilator $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/desc64_frontend_props.sv ====
// ==================================================
// handshake, irq and reset assertions of the front
// end, bound into the top level from this file
// ==================================================

`timescale 1ns/1ps

module desc64_frontend_props import desc64_pkg::*; (
    input logic                  clk_i,
    input logic                  arst_n_i,
    input logic                  ar_valid_i,
    input logic [ADDR_WIDTH-1:0] ar_addr_i,
    input logic                  ar_ready_i,
    input logic                  req_valid_i,
    input logic [ADDR_WIDTH-1:0] req_src_i,
    input logic [ADDR_WIDTH-1:0] req_dst_i,
    input logic [LEN_WIDTH-1:0]  req_len_i,
    input logic                  req_ready_i,
    input logic                  irq_i,
    input logic                  busy_i
);

    logic ar_bad = 1'b0;
    logic req_bad = 1'b0;
    logic irq_bad = 1'b0;
    logic rst_bad = 1'b0;
    logic props_failed;

    assign props_failed = ar_bad || req_bad || irq_bad || rst_bad;

    a_ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else begin
        ar_bad = 1'b1;
        $error("read address dropped or changed before its handshake");
    end

    // payload must hold while the back end stalls
    a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_src_i)
            && $stable(req_dst_i) && $stable(req_len_i))
    else begin
        req_bad = 1'b1;
        $error("request dropped or changed before its handshake");
    end

    a_irq_after_pop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_i |-> $past(req_valid_i && req_ready_i))
    else begin
        irq_bad = 1'b1;
        $error("irq pulse without a request handshake in the cycle before");
    end

    a_reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> !ar_valid_i && !req_valid_i && !irq_i && !busy_i)
    else begin
        rst_bad = 1'b1;
        $error("control output active during reset");
    end

endmodule

bind desc64_frontend desc64_frontend_props i_props (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ar_valid_i  (ar_valid_o),
    .ar_addr_i   (ar_addr_o),
    .ar_ready_i  (ar_ready_i),
    .req_valid_i (req_valid_o),
    .req_src_i   (req_src_o),
    .req_dst_i   (req_dst_o),
    .req_len_i   (req_len_o),
    .req_ready_i (req_ready_i),
    .irq_i       (irq_o),
    .busy_i      (busy_o)
);

// ==== bench/tb_desc64_frontend.sv ====
// ==================================================
// testbench of the descriptor front end: a memory
// model answers descriptor reads, a reference walk
// of each chain gives the expected requests
// ==================================================

`timescale 1ns/1ps

module tb_desc64_frontend import desc64_pkg::*; ();

    // descriptors over all tests set the cycle limit
    localparam int unsigned TOTAL_DESCS = 39;
    localparam int unsigned CYCLE_LIMIT = TOTAL_DESCS * 40 + 200;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  doorbell_valid_i;
    logic [ADDR_WIDTH-1:0] doorbell_addr_i;
    logic                  doorbell_ready_o;
    logic                  ar_valid_o;
    logic [ADDR_WIDTH-1:0] ar_addr_o;
    logic                  ar_ready_i;
    logic                  r_valid_i;
    logic [DATA_WIDTH-1:0] r_data_i;
    logic                  r_last_i;
    logic                  r_ready_o;
    logic                  req_valid_o;
    logic [ADDR_WIDTH-1:0] req_src_o;
    logic [ADDR_WIDTH-1:0] req_dst_o;
    logic [LEN_WIDTH-1:0]  req_len_o;
    logic                  req_ready_i;
    logic                  irq_o;
    logic                  busy_o;

    // descriptor memory keyed by the byte address of each 64 bit word
    logic [DATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];
    logic [ADDR_WIDTH-1:0] exp_ar_q [$];
    logic [ADDR_WIDTH-1:0] exp_src_q [$];
    logic [ADDR_WIDTH-1:0] exp_dst_q [$];
    logic [LEN_WIDTH-1:0]  exp_len_q [$];
    logic                  exp_irq_q [$];
    logic [ADDR_WIDTH-1:0] ar_pending_q [$];
    logic                  hold_req_ready = 1'b0;
    logic                  irq_exp = 1'b0;
    int unsigned           cycle_cnt = 0;
    // last beats taken on the read data channel
    int unsigned           last_beats = 0;
    int unsigned           last_beats_start = 0;

    desc64_frontend i_dut (.*);

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic next_drive_point();
        @(posedge clk_i);
        #10;
    endtask

    // expected requests of one chain, from the descriptor layout
    function automatic void walk_chain(input logic [ADDR_WIDTH-1:0] start);
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] flags_len;
        addr = start;
        while (addr != END_OF_CHAIN) begin
            flags_len = mem[addr];
            exp_ar_q.push_back(addr);
            exp_len_q.push_back(flags_len[LEN_WIDTH-1:0]);
            exp_irq_q.push_back(flags_len[LEN_WIDTH + IRQ_FLAG_BIT]);
            exp_src_q.push_back(mem[addr + 64'd16]);
            exp_dst_q.push_back(mem[addr + 64'd24]);
            addr = mem[addr + 64'd8];
        end
    endfunction

    // irq_mode 0 none, 1 all, 2 alternating, otherwise random
    task automatic run_chain(input int n, input logic [ADDR_WIDTH-1:0] base,
                             input int irq_mode);
        logic [ADDR_WIDTH-1:0] addrs [8];
        logic [31:0]           flags;
        logic                  taken;
        for (int i = 0; i < n; i++) begin
            addrs[i] = base + 64'((i * 5) % 7) * 64'h1_0000 + 64'($urandom % 128) * 64'h20;
        end
        for (int i = 0; i < n; i++) begin
            flags = $urandom;
            flags[IRQ_FLAG_BIT] = (irq_mode == 0) ? 1'b0 : (irq_mode == 1) ? 1'b1 :
                                  (irq_mode == 2) ? 1'(i % 2) : 1'($urandom % 2);
            mem[addrs[i]]          = {flags, 32'($urandom)};
            mem[addrs[i] + 64'd8]  = (i == n - 1) ? END_OF_CHAIN : addrs[i + 1];
            mem[addrs[i] + 64'd16] = {$urandom, $urandom};
            mem[addrs[i] + 64'd24] = {$urandom, $urandom};
        end
        walk_chain(addrs[0]);
        doorbell_valid_i = 1'b1;
        doorbell_addr_i  = addrs[0];
        do begin
            @(negedge clk_i);
            taken = doorbell_ready_o;
            next_drive_point();
        end while (!taken);
        doorbell_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        do @(negedge clk_i); while (busy_o || exp_src_q.size() != 0);
        next_drive_point();
        check_value("ar_valid_o", 64'(ar_valid_o), 64'd0);
        check_value("req_valid_o", 64'(req_valid_o), 64'd0);
        check_value("irq_o", 64'(irq_o), 64'd0);
        check_value("busy_o", 64'(busy_o), 64'd0);
        check_value("doorbell_ready_o", 64'(doorbell_ready_o), 64'd1);
        check_value("r_ready_o", 64'(r_ready_o), 64'd1);
    endtask

    // memory model sends one descriptor per accepted read address
    task automatic send_descriptor(input logic [ADDR_WIDTH-1:0] addr);
        logic taken;
        repeat ($urandom % 4) next_drive_point();
        for (int b = 0; b < DESC_BEATS; b++) begin
            repeat ($urandom % 3) next_drive_point();
            r_valid_i = 1'b1;
            r_data_i  = mem[addr + 64'(8 * b)];
            r_last_i  = (b == DESC_BEATS - 1);
            do begin
                @(negedge clk_i);
                taken = r_ready_o;
                next_drive_point();
            end while (!taken);
            r_valid_i = 1'b0;
            r_last_i  = 1'b0;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    initial begin
        r_valid_i = 1'b0;
        r_data_i  = '0;
        r_last_i  = 1'b0;
        forever begin
            next_drive_point();
            if (ar_pending_q.size() != 0) begin
                send_descriptor(ar_pending_q.pop_front());
            end
        end
    end

    // ready lines toggle at random unless the queue test holds req_ready_i low
    initial begin : ready_driver
        logic hold_now;
        ar_ready_i  = 1'b0;
        req_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            hold_now = hold_req_ready;
            #10;
            ar_ready_i  = ($urandom % 4) != 0;
            req_ready_i = hold_now ? 1'b0 : (($urandom % 3) != 0);
        end
    end

    // compare process samples mid cycle where all handshake signals are settled
    initial begin
        forever begin
            @(negedge clk_i);
            if (arst_n_i) begin
                check_value("irq_o", 64'(irq_o), 64'(irq_exp));
                irq_exp = 1'b0;
                if (r_valid_i && r_ready_o && r_last_i) begin
                    last_beats = last_beats + 1;
                end
                if (ar_valid_o && ar_ready_i) begin
                    if (exp_ar_q.size() == 0) begin
                        fail_now("read address issued beyond the end of the chain");
                    end else begin
                        check_value("ar_addr_o", ar_addr_o, exp_ar_q.pop_front());
                        ar_pending_q.push_back(ar_addr_o);
                    end
                end
                if (req_valid_o && req_ready_i) begin
                    if (exp_src_q.size() == 0) begin
                        fail_now("request delivered with no descriptor left to expect");
                    end else begin
                        check_value("req_src_o", req_src_o, exp_src_q.pop_front());
                        check_value("req_dst_o", req_dst_o, exp_dst_q.pop_front());
                        check_value("req_len_o", 64'(req_len_o), 64'(exp_len_q.pop_front()));
                        irq_exp = exp_irq_q.pop_front();
                    end
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk_i);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > CYCLE_LIMIT) begin
                fail_now($sformatf("timeout: run still going after %0d cycles", CYCLE_LIMIT));
            end
        end
    end

    initial begin
        void'($urandom(32'h992b));
        doorbell_valid_i = 1'b0;
        doorbell_addr_i  = '0;
        arst_n_i         = 1'b1;
        #5;
        arst_n_i = 1'b0;
        repeat (5) @(posedge clk_i);
        #10;
        arst_n_i = 1'b1;
        wait_drained();

        // single descriptor, then a six deep chain and one with alternating irq
        run_chain(1, 64'h1_0000_0000, 1);
        wait_drained();
        run_chain(6, 64'h2_0000_0000, 0);
        wait_drained();
        run_chain(6, 64'h3_0000_0000, 2);
        wait_drained();

        // back pressure fills the queue and stalls the read data
        hold_req_ready   = 1'b1;
        last_beats_start = last_beats;
        run_chain(6, 64'h4_0000_0000, 3);
        do @(negedge clk_i); while (r_ready_o);
        next_drive_point();
        check_value("req_valid_o", 64'(req_valid_o), 64'd1);
        check_value("accepted descriptors", 64'(last_beats - last_beats_start),
                    64'(QUEUE_DEPTH));
        hold_req_ready = 1'b0;
        wait_drained();

        // chains rung back to back under random gaps
        for (int k = 0; k < 4; k++) begin
            run_chain(5, 64'h10_0000_0000 + 64'(k) * 64'h1_0000_0000, 3);
        end
        wait_drained();

        if (!i_dut.i_props.props_failed) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_now("handshake assertions failed during the run");
        end
    end

endmodule

// ==== common/desc64_pkg.sv ====
// ================================================
// shared constants and types of the descriptor
// chain front end; every RTL file of the front end
// pulls these in by a wildcard import
// ================================================

package desc64_pkg;

    // bus geometry
    localparam int unsigned ADDR_WIDTH = 64;
    localparam int unsigned DATA_WIDTH = 64;

    // the first beat splits into flags (upper half) and length (lower half)
    localparam int unsigned LEN_WIDTH   = 32;
    localparam int unsigned FLAGS_WIDTH = DATA_WIDTH - LEN_WIDTH;

    // bit within the flags field that asks for an interrupt
    localparam int unsigned IRQ_FLAG_BIT = 0;

    // a descriptor is four beats of one read burst
    localparam int unsigned DESC_BEATS     = 4;
    localparam int unsigned BEAT_IDX_WIDTH = $clog2(DESC_BEATS);

    // next pointer value that terminates a chain
    localparam logic [ADDR_WIDTH-1:0] END_OF_CHAIN = '1;

    // request queue sizing
    localparam int unsigned QUEUE_DEPTH     = 4;
    localparam int unsigned QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    // the fill count must also hold the value QUEUE_DEPTH
    localparam int unsigned COUNT_WIDTH     = $clog2(QUEUE_DEPTH + 1);

    // beat order inside one descriptor, as it arrives on the read channel
    //   BEAT_FLAGS_LEN : flags [63:32], length [31:0]
    //   BEAT_NEXT      : address of the next descriptor
    //   BEAT_SRC       : transfer source address
    //   BEAT_DST       : transfer destination address, always the last beat
    typedef enum logic [BEAT_IDX_WIDTH-1:0] {
        BEAT_FLAGS_LEN = 2'd0,
        BEAT_NEXT      = 2'd1,
        BEAT_SRC       = 2'd2,
        BEAT_DST       = 2'd3
    } beat_idx_e;

    // fetch controller states
    //   FETCH_IDLE  : waiting for a doorbell
    //   FETCH_ADDR  : read address presented, waiting for the handshake
    //   FETCH_DATA  : beats in flight, next pointer not yet seen
    //   FETCH_DRAIN : next pointer latched, waiting for the last beat
    typedef enum logic [1:0] {
        FETCH_IDLE  = 2'd0,
        FETCH_ADDR  = 2'd1,
        FETCH_DATA  = 2'd2,
        FETCH_DRAIN = 2'd3
    } fetch_state_e;

endpackage

// ==== desc_reader/desc_reader.sv ====
// ================================================
// collects the four read beats of a descriptor and
// hands the request to the queue on the last beat;
// next pointer goes to the fetch controller
// ================================================

`timescale 1ns/1ps

module desc_reader import desc64_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // read data channel
    input  logic                  r_valid_i,
    input  logic [DATA_WIDTH-1:0] r_data_i,
    input  logic                  r_last_i,
    output logic                  r_ready_o,
    // back pressure from the request queue
    input  logic                  not_full_i,
    // chain walking
    output logic [ADDR_WIDTH-1:0] next_addr_o,
    output logic                  next_addr_valid_o,
    output logic                  desc_done_o,
    // assembled request
    output logic                  push_valid_o,
    output logic [ADDR_WIDTH-1:0] push_src_o,
    output logic [ADDR_WIDTH-1:0] push_dst_o,
    output logic [LEN_WIDTH-1:0]  push_len_o,
    output logic                  push_irq_o
);

    beat_idx_e               beat_cnt_q;
    logic [DATA_WIDTH-1:0]   beats_q [DESC_BEATS-1];
    logic                    beat_fire;
    logic                    last_fire;
    logic [FLAGS_WIDTH-1:0]  flags;

    // a beat is only taken when the queue can hold the resulting request
    assign r_ready_o = not_full_i;
    assign beat_fire = r_valid_i && r_ready_o;
    assign last_fire = beat_fire && r_last_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            beat_cnt_q <= BEAT_FLAGS_LEN;
        end else if (last_fire) begin
            beat_cnt_q <= BEAT_FLAGS_LEN;
        end else if (beat_fire) begin
            beat_cnt_q <= beat_idx_e'(beat_cnt_q + 1'b1);
        end
    end

    // the destination beat is used straight off the bus, so only
    // the first three beats need storage
    always_ff @(posedge clk_i) begin
        if (beat_fire && !r_last_i && (beat_cnt_q != BEAT_DST)) begin
            beats_q[beat_cnt_q] <= r_data_i;
        end
    end

    // next pointer is stable from the cycle after BEAT_NEXT
    // until the last beat of this descriptor is taken
    assign next_addr_o       = beats_q[BEAT_NEXT][ADDR_WIDTH-1:0];
    assign next_addr_valid_o = (beat_cnt_q == BEAT_SRC) || (beat_cnt_q == BEAT_DST);
    assign desc_done_o       = last_fire;

    // request fields
    assign flags        = beats_q[BEAT_FLAGS_LEN][DATA_WIDTH-1:LEN_WIDTH];
    assign push_valid_o = last_fire;
    assign push_src_o   = beats_q[BEAT_SRC][ADDR_WIDTH-1:0];
    assign push_dst_o   = r_data_i[ADDR_WIDTH-1:0];
    assign push_len_o   = beats_q[BEAT_FLAGS_LEN][LEN_WIDTH-1:0];
    assign push_irq_o   = flags[IRQ_FLAG_BIT];

endmodule

// ==== logic/desc64_frontend.sv ====
// ================================================
// top of the descriptor chain front end: doorbell
// in, descriptor reads out, transfer requests and
// interrupt pulses towards the DMA back end
// ================================================

`timescale 1ns/1ps

module desc64_frontend import desc64_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // doorbell
    input  logic                  doorbell_valid_i,
    input  logic [ADDR_WIDTH-1:0] doorbell_addr_i,
    output logic                  doorbell_ready_o,
    // read address channel
    output logic                  ar_valid_o,
    output logic [ADDR_WIDTH-1:0] ar_addr_o,
    input  logic                  ar_ready_i,
    // read data channel
    input  logic                  r_valid_i,
    input  logic [DATA_WIDTH-1:0] r_data_i,
    input  logic                  r_last_i,
    output logic                  r_ready_o,
    // transfer requests
    output logic                  req_valid_o,
    output logic [ADDR_WIDTH-1:0] req_src_o,
    output logic [ADDR_WIDTH-1:0] req_dst_o,
    output logic [LEN_WIDTH-1:0]  req_len_o,
    input  logic                  req_ready_i,
    // status
    output logic                  irq_o,
    output logic                  busy_o
);

    logic [ADDR_WIDTH-1:0] next_addr;
    logic                  next_addr_valid;
    logic                  desc_done;
    logic                  push_valid;
    logic [ADDR_WIDTH-1:0] push_src;
    logic [ADDR_WIDTH-1:0] push_dst;
    logic [LEN_WIDTH-1:0]  push_len;
    logic                  push_irq;
    logic                  not_full;
    logic                  queue_empty;
    logic                  fetch_idle;

    desc_reader i_reader (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .r_valid_i         (r_valid_i),
        .r_data_i          (r_data_i),
        .r_last_i          (r_last_i),
        .r_ready_o         (r_ready_o),
        .not_full_i        (not_full),
        .next_addr_o       (next_addr),
        .next_addr_valid_o (next_addr_valid),
        .desc_done_o       (desc_done),
        .push_valid_o      (push_valid),
        .push_src_o        (push_src),
        .push_dst_o        (push_dst),
        .push_len_o        (push_len),
        .push_irq_o        (push_irq)
    );

    desc_fetch_ctrl i_fetch (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .doorbell_valid_i  (doorbell_valid_i),
        .doorbell_addr_i   (doorbell_addr_i),
        .doorbell_ready_o  (doorbell_ready_o),
        .ar_valid_o        (ar_valid_o),
        .ar_addr_o         (ar_addr_o),
        .ar_ready_i        (ar_ready_i),
        .next_addr_i       (next_addr),
        .next_addr_valid_i (next_addr_valid),
        .desc_done_i       (desc_done),
        .idle_o            (fetch_idle)
    );

    desc_req_queue i_queue (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (push_valid),
        .push_src_i   (push_src),
        .push_dst_i   (push_dst),
        .push_len_i   (push_len),
        .push_irq_i   (push_irq),
        .not_full_o   (not_full),
        .empty_o      (queue_empty),
        .req_valid_o  (req_valid_o),
        .req_src_o    (req_src_o),
        .req_dst_o    (req_dst_o),
        .req_len_o    (req_len_o),
        .req_ready_i  (req_ready_i),
        .irq_o        (irq_o)
    );

    // busy while a chain is walked or requests still wait downstream
    assign busy_o = !fetch_idle || !queue_empty;

endmodule

// ==== logic/desc_fetch_ctrl.sv ====
// ================================================
// takes the doorbell, issues one descriptor read at
// a time and follows next pointers until the end of
// chain marker shows up
// ================================================

`timescale 1ns/1ps

module desc_fetch_ctrl import desc64_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // doorbell from software
    input  logic                  doorbell_valid_i,
    input  logic [ADDR_WIDTH-1:0] doorbell_addr_i,
    output logic                  doorbell_ready_o,
    // read address channel
    output logic                  ar_valid_o,
    output logic [ADDR_WIDTH-1:0] ar_addr_o,
    input  logic                  ar_ready_i,
    // from the descriptor reader
    input  logic [ADDR_WIDTH-1:0] next_addr_i,
    input  logic                  next_addr_valid_i,
    input  logic                  desc_done_i,
    output logic                  idle_o
);

    fetch_state_e          state_q;
    fetch_state_e          state_d;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH-1:0] next_q;
    logic [ADDR_WIDTH-1:0] next_sel;
    logic                  doorbell_fire;
    logic                  ar_fire;
    logic                  load_next;
    logic                  done_fire;
    logic                  chain_end;

    assign doorbell_ready_o = (state_q == FETCH_IDLE);
    assign doorbell_fire    = doorbell_valid_i && doorbell_ready_o;
    assign ar_valid_o       = (state_q == FETCH_ADDR);
    assign ar_addr_o        = addr_q;
    assign ar_fire          = ar_valid_o && ar_ready_i;
    assign idle_o           = (state_q == FETCH_IDLE);

    assign load_next = (state_q == FETCH_DATA) && next_addr_valid_i;

    // last beat normally lands in FETCH_DRAIN; if it shows up while still
    // in FETCH_DATA the live pointer from the reader is used instead
    assign done_fire = desc_done_i && ((state_q == FETCH_DRAIN) || load_next);
    assign next_sel  = (state_q == FETCH_DRAIN) ? next_q : next_addr_i;
    assign chain_end = (next_sel == END_OF_CHAIN);

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: begin
                if (doorbell_fire) begin
                    state_d = FETCH_ADDR;
                end
            end
            FETCH_ADDR: begin
                if (ar_fire) begin
                    state_d = FETCH_DATA;
                end
            end
            FETCH_DATA: begin
                if (done_fire) begin
                    state_d = chain_end ? FETCH_IDLE : FETCH_ADDR;
                end else if (load_next) begin
                    state_d = FETCH_DRAIN;
                end
            end
            FETCH_DRAIN: begin
                if (done_fire) begin
                    state_d = chain_end ? FETCH_IDLE : FETCH_ADDR;
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // read address comes from the doorbell or from the chain
    always_ff @(posedge clk_i) begin
        if (doorbell_fire) begin
            addr_q <= doorbell_addr_i;
        end else if (done_fire && !chain_end) begin
            addr_q <= next_sel;
        end
        if (load_next) begin
            next_q <= next_addr_i;
        end
    end

endmodule

// ==== logic/desc_req_queue.sv ====
// ================================================
// four entry request queue between the reader and
// the DMA back end; pulses irq_o after a flagged
// entry leaves through the output handshake
// ================================================

`timescale 1ns/1ps

module desc_req_queue import desc64_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // write side, from the reader
    input  logic                  push_valid_i,
    input  logic [ADDR_WIDTH-1:0] push_src_i,
    input  logic [ADDR_WIDTH-1:0] push_dst_i,
    input  logic [LEN_WIDTH-1:0]  push_len_i,
    input  logic                  push_irq_i,
    output logic                  not_full_o,
    output logic                  empty_o,
    // read side, towards the back end
    output logic                  req_valid_o,
    output logic [ADDR_WIDTH-1:0] req_src_o,
    output logic [ADDR_WIDTH-1:0] req_dst_o,
    output logic [LEN_WIDTH-1:0]  req_len_o,
    input  logic                  req_ready_i,
    output logic                  irq_o
);

    logic [ADDR_WIDTH-1:0]      src_mem [QUEUE_DEPTH];
    logic [ADDR_WIDTH-1:0]      dst_mem [QUEUE_DEPTH];
    logic [LEN_WIDTH-1:0]       len_mem [QUEUE_DEPTH];
    logic                       irq_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr_q;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr_q;
    logic [COUNT_WIDTH-1:0]     count_q;
    logic                       push;
    logic                       pop;

    assign not_full_o  = (count_q != COUNT_WIDTH'(QUEUE_DEPTH));
    assign empty_o     = (count_q == '0);
    assign req_valid_o = !empty_o;
    assign req_src_o   = src_mem[rd_ptr_q];
    assign req_dst_o   = dst_mem[rd_ptr_q];
    assign req_len_o   = len_mem[rd_ptr_q];

    assign push = push_valid_i && not_full_o;
    assign pop  = req_valid_o && req_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            src_mem[wr_ptr_q] <= push_src_i;
            dst_mem[wr_ptr_q] <= push_dst_i;
            len_mem[wr_ptr_q] <= push_len_i;
            irq_mem[wr_ptr_q] <= push_irq_i;
        end
    end

    // pointers wrap at QUEUE_DEPTH, count tracks the fill level
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            irq_o    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
            irq_o <= pop && irq_mem[rd_ptr_q];
        end
    end

endmodule

// ==== project.f ====
common/desc64_pkg.sv
desc_reader/desc_reader.sv
logic/desc_fetch_ctrl.sv
logic/desc_req_queue.sv
logic/desc64_frontend.sv
bench/desc64_frontend_props.sv
bench/tb_desc64_frontend.sv
